/* tb.f */
+incdir+.
icache_pkg.sv
icache_way.sv
icache_lookup.sv
icache_way_select.sv
icache_refill.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_icache -o sim_icache
./obj_dir/sim_icache | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* tb_icache.sv */
// ========================================
// directed testbench for the two-way instruction cache
// cold miss, line hits, PLRU, invalidate, back-pressure
// ========================================

`timescale 1ns/1ps
`default_nettype none

module tb_icache
  import icache_pkg::*;
();

  // about 45 fetches, a refill costs roughly 12 cycles
  localparam int unsigned MAX_CYCLES = 4000;

  logic        clk;
  logic        rst_n;
  fetch_req_t  fetch_req;
  logic        fetch_ready;
  fetch_rsp_t  fetch_rsp;
  logic        rsp_ready;
  inval_req_t  inval_req;
  logic        inval_ready;
  axi_ar_t     axi_ar;
  logic        ar_ready;
  axi_r_t      axi_r;
  logic [31:0] ar_count;
  logic [31:0] ar_addr;
  logic [7:0]  ar_len;
  integer      seed;
  int unsigned cycle_cnt = 0;

  icache_top i_icache_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_ready_o (fetch_ready),
    .fetch_rsp_o   (fetch_rsp),
    .rsp_ready_i   (rsp_ready),
    .inval_req_i   (inval_req),
    .inval_ready_o (inval_ready),
    .axi_ar_o      (axi_ar),
    .ar_ready_i    (ar_ready),
    .axi_r_i       (axi_r)
  );

  tb_icache_mem i_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .axi_ar_i   (axi_ar),
    .ar_ready_o (ar_ready),
    .axi_r_o    (axi_r),
    .ar_count_o (ar_count),
    .ar_addr_o  (ar_addr),
    .ar_len_o   (ar_len)
  );

  always #10 clk = ~clk;

  // ========================================
  // reporting and checks
  // ========================================
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      stop_on_error($sformatf("error at %0t: %s", $time, what));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      stop_on_error("timeout: the tests did not finish within the cycle limit");
    end
  end

  // memory contents for a word address
  function automatic logic [31:0] word_rule(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  // one fetch with rsp_ready high, checks the returned word
  task automatic fetch_and_check(input logic [31:0] addr);
    @(posedge clk);
    fetch_req <= {1'b1, addr};
    @(negedge clk);
    while (!fetch_ready) @(negedge clk);
    @(posedge clk);
    fetch_req <= '0;
    @(negedge clk);
    while (!fetch_rsp.valid) @(negedge clk);
    check_equal("fetch_rsp_o.vaddr", fetch_rsp.vaddr, addr);
    check_equal("fetch_rsp_o.instr", fetch_rsp.instr, word_rule(addr));
  endtask

  task automatic fetch_expect_ar(input logic [31:0] addr, input logic [31:0] delta);
    logic [31:0] n0;
    n0 = ar_count;
    fetch_and_check(addr);
    check_equal("ar_count", ar_count, n0 + delta);
  endtask

  task automatic invalidate_line(input idx_t idx, input logic way);
    @(posedge clk);
    inval_req <= {1'b1, idx, way};
    @(negedge clk);
    while (!inval_ready) @(negedge clk);
    check_true(!fetch_ready, "fetch_ready_o high while an invalidate is presented");
    @(posedge clk);
    inval_req <= '0;
    @(negedge clk);
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic check_reset_state();
    @(negedge clk);
    check_true(fetch_ready && inval_ready, "ready outputs low after reset");
    check_true(!fetch_rsp.valid && !axi_ar.valid, "valid outputs high after reset");
  endtask

  task automatic test_cold_miss();
    fetch_expect_ar(32'h0000_1238, 32'd1);
    check_equal("axi_ar_o.addr", ar_addr, 32'h0000_1230);
    check_equal("axi_ar_o.len", {24'h0, ar_len}, 32'd3);
  endtask

  task automatic test_line_hits();
    for (int w = 0; w < 4; w++) begin
      fetch_expect_ar(32'h0000_1230 + 32'(4 * w), 32'd0);
    end
  endtask

  // set 5: A fills way 0, B way 1, C then evicts B
  task automatic test_plru_replacement();
    fetch_expect_ar(32'h0000_2050, 32'd1);
    fetch_expect_ar(32'h0000_3054, 32'd1);
    fetch_expect_ar(32'h0000_2058, 32'd0);
    fetch_expect_ar(32'h0000_405c, 32'd1);
    fetch_expect_ar(32'h0000_2050, 32'd0);
    fetch_expect_ar(32'h0000_3050, 32'd1);
  endtask

  // A sits in way 0, B was refetched into way 1
  task automatic test_invalidate();
    invalidate_line(4'd5, 1'b0);
    fetch_expect_ar(32'h0000_2054, 32'd1);
    fetch_expect_ar(32'h0000_3058, 32'd0);
  endtask

  task automatic test_back_pressure();
    logic [31:0] bp_addr;
    bp_addr = 32'h0000_1234;
    @(posedge clk);
    rsp_ready <= 1'b0;
    fetch_req <= {1'b1, bp_addr};
    @(negedge clk);
    while (!fetch_ready) @(negedge clk);
    @(posedge clk);
    fetch_req <= '0;
    @(negedge clk);
    while (!fetch_rsp.valid) @(negedge clk);
    check_equal("fetch_rsp_o.vaddr", fetch_rsp.vaddr, bp_addr);
    check_equal("fetch_rsp_o.instr", fetch_rsp.instr, word_rule(bp_addr));
    repeat (6) begin
      @(negedge clk);
      check_true(fetch_rsp.valid, "fetch_rsp_o.valid dropped under back-pressure");
      check_equal("fetch_rsp_o.vaddr", fetch_rsp.vaddr, bp_addr);
      check_equal("fetch_rsp_o.instr", fetch_rsp.instr, word_rule(bp_addr));
      check_true(!fetch_ready, "fetch_ready_o high under back-pressure");
    end
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(negedge clk);
  endtask

  task automatic test_random_stream();
    logic [31:0] addrs [30];
    logic [31:0] exp_q [$];
    logic [31:0] rnd;
    logic [31:0] exp_addr;
    int          n_rsp;
    // four tags over all sets, so hits and misses mix
    for (int k = 0; k < 30; k++) begin
      rnd = $random(seed);
      addrs[k] = 32'h0000_6000 | (rnd & 32'h0000_03fc);
    end
    n_rsp = 0;
    fork
      begin : drive
        for (int k = 0; k < 30; k++) begin
          @(posedge clk);
          fetch_req <= {1'b1, addrs[k]};
          @(negedge clk);
          while (!fetch_ready) @(negedge clk);
          exp_q.push_back(addrs[k]);
        end
        @(posedge clk);
        fetch_req <= '0;
      end
      begin : collect
        while (n_rsp < 30) begin
          @(posedge clk);
          rnd = $random(seed);
          rsp_ready <= rnd[0];
          @(negedge clk);
          if (fetch_rsp.valid && rsp_ready) begin
            check_true(exp_q.size() != 0, "response arrived with no fetch outstanding");
            exp_addr = exp_q.pop_front();
            check_equal("fetch_rsp_o.vaddr", fetch_rsp.vaddr, exp_addr);
            check_equal("fetch_rsp_o.instr", fetch_rsp.instr, word_rule(exp_addr));
            n_rsp++;
          end
        end
        @(posedge clk);
        rsp_ready <= 1'b1;
      end
    join
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    fetch_req = '0;
    rsp_ready = 1'b1;
    inval_req = '0;
    seed      = 32'hb79e_6003;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    test_cold_miss();
    test_line_hits();
    test_plru_replacement();
    test_invalidate();
    test_back_pressure();
    test_random_stream();
    @(posedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : tb_icache

`default_nettype wire

/* tb_icache_mem.sv */
// ========================================
// testbench memory model for the cache AR/R bus
// accepts an AR after two cycles, answers with an INCR burst
// ========================================

`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem
  import icache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  axi_ar_t     axi_ar_i,
  output logic        ar_ready_o,
  output axi_r_t      axi_r_o,
  output logic [31:0] ar_count_o,
  output logic [31:0] ar_addr_o,
  output logic [7:0]  ar_len_o
);

  logic [1:0]  wait_q;
  logic        sending_q;
  logic [8:0]  beats_left_q;
  logic [31:0] beat_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_o   <= 1'b0;
      axi_r_o      <= '0;
      ar_count_o   <= '0;
      ar_addr_o    <= '0;
      ar_len_o     <= '0;
      wait_q       <= '0;
      sending_q    <= 1'b0;
      beats_left_q <= '0;
      beat_addr_q  <= '0;
    end else begin
      ar_ready_o <= 1'b0;
      if (axi_ar_i.valid && ar_ready_o) begin
        // burst accepted, remember it for the checks
        ar_count_o   <= ar_count_o + 32'd1;
        ar_addr_o    <= axi_ar_i.addr;
        ar_len_o     <= axi_ar_i.len;
        beat_addr_q  <= axi_ar_i.addr;
        beats_left_q <= {1'b0, axi_ar_i.len} + 9'd1;
        sending_q    <= 1'b1;
        wait_q       <= '0;
      end else if (sending_q) begin
        if (beats_left_q != 9'd0) begin
          axi_r_o.valid <= 1'b1;
          axi_r_o.data  <= beat_addr_q ^ 32'h5a5a_0000;
          axi_r_o.last  <= (beats_left_q == 9'd1);
          beat_addr_q   <= beat_addr_q + 32'd4;
          beats_left_q  <= beats_left_q - 9'd1;
        end else begin
          axi_r_o   <= '0;
          sending_q <= 1'b0;
        end
      end else if (axi_ar_i.valid) begin
        // ready rises once valid has waited two cycles
        if (wait_q == 2'd1) begin
          ar_ready_o <= 1'b1;
        end else begin
          wait_q <= wait_q + 2'd1;
        end
      end
    end
  end

endmodule : tb_icache_mem

`default_nettype wire

/* icache_top.sv */
// ======================================
// two-way instruction cache top level
// lookup front, way array loop, way select, refill
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       rsp_ready_i,
  input  inval_req_t inval_req_i,
  output logic       inval_ready_o,
  output axi_ar_t    axi_ar_o,
  input  logic       ar_ready_i,
  input  axi_r_t     axi_r_i
);

  idx_t                                rd_idx;
  idx_t                                clr_idx;
  tag_t                                s1_tag;
  logic [`ICACHE_ADDR_WIDTH-1:0]       s1_vaddr;
  logic                                s1_fetch;
  logic [`ICACHE_WAY_NUM-1:0]          clr_way;
  way_rd_t [`ICACHE_WAY_NUM-1:0]       way_rd;
  way_wr_t                             fill;
  logic                                miss;
  logic                                busy;
  logic [$clog2(`ICACHE_WAY_NUM)-1:0] victim;

  icache_lookup i_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .inval_req_i   (inval_req_i),
    .inval_ready_o (inval_ready_o),
    .rsp_ready_i   (rsp_ready_i),
    .miss_i        (miss),
    .busy_i        (busy),
    .rd_idx_o      (rd_idx),
    .s1_tag_o      (s1_tag),
    .s1_vaddr_o    (s1_vaddr),
    .s1_fetch_o    (s1_fetch),
    .clr_way_o     (clr_way),
    .clr_idx_o     (clr_idx)
  );

  // per-way enables split off the one-hot vectors
  for (genvar i = 0; i < `ICACHE_WAY_NUM; i++) begin : gen_way
    icache_way i_way (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_i  (rd_idx),
      .s1_tag_i  (s1_tag),
      .fill_i    (fill),
      .fill_en_i (fill.way_en[i]),
      .clr_en_i  (clr_way[i]),
      .clr_idx_i (clr_idx),
      .rd_o      (way_rd[i])
    );
  end

  icache_way_select i_way_select (
    .clk         (clk),
    .rst_n       (rst_n),
    .way_rd_i    (way_rd),
    .s1_vaddr_i  (s1_vaddr),
    .s1_fetch_i  (s1_fetch),
    .fetch_rsp_o (fetch_rsp_o),
    .miss_o      (miss),
    .victim_o    (victim)
  );

  icache_refill i_refill (
    .clk        (clk),
    .rst_n      (rst_n),
    .miss_i     (miss),
    .s1_fetch_i (s1_fetch),
    .s1_vaddr_i (s1_vaddr),
    .victim_i   (victim),
    .axi_ar_o   (axi_ar_o),
    .ar_ready_i (ar_ready_i),
    .axi_r_i    (axi_r_i),
    .fill_o     (fill),
    .busy_o     (busy)
  );

endmodule : icache_top

`default_nettype wire

/* icache_refill.sv */
// ======================================
// refill FSM for a missing line
// one AR burst, collects R beats, fills the victim way
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_refill
  import icache_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                miss_i,
  input  logic                                s1_fetch_i,
  input  logic [`ICACHE_ADDR_WIDTH-1:0]       s1_vaddr_i,
  input  logic [$clog2(`ICACHE_WAY_NUM)-1:0] victim_i,
  output axi_ar_t                             axi_ar_o,
  input  logic                                ar_ready_i,
  input  axi_r_t                              axi_r_i,
  output way_wr_t                             fill_o,
  output logic                                busy_o
);

  refill_state_e state_q;
  refill_state_e state_d;

  logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_q;
  line_t                                 beat_buf_q;
  line_t                                 fill_line;
  logic                                  last_beat;
  // ways re-read the filled set in the cycle after the fill
  logic                                  reread_q;

  assign last_beat = (state_q == REFILL) & axi_r_i.valid & axi_r_i.last;

  // ======================================
  // state machine
  // ======================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (miss_i && s1_fetch_i && !reread_q) begin
          state_d = MISS;
        end
      end
      MISS: begin
        if (ar_ready_i) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (last_beat) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      beat_q   <= '0;
      reread_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      reread_q <= last_beat;
      if (last_beat) begin
        beat_q <= '0;
      end else if (state_q == REFILL && axi_r_i.valid) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // beat collection, r_ready is implied in REFILL
  always_ff @(posedge clk) begin
    if (state_q == REFILL && axi_r_i.valid) begin
      beat_buf_q[beat_q] <= axi_r_i.data;
    end
  end

  assign axi_ar_o.valid = (state_q == MISS);
  assign axi_ar_o.addr  = {s1_vaddr_i[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFS_WIDTH],
                           {`ICACHE_OFS_WIDTH{1'b0}}};
  assign axi_ar_o.len   = 8'(`ICACHE_LINE_WORDS - 1);

  // last beat goes straight into the line
  always_comb begin
    fill_line         = beat_buf_q;
    fill_line[beat_q] = axi_r_i.data;

    fill_o.way_en = '0;
    if (last_beat && s1_fetch_i) begin
      fill_o.way_en[victim_i] = 1'b1;
    end
    fill_o.idx  = s1_vaddr_i[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH];
    fill_o.tag  = s1_vaddr_i[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
    fill_o.line = fill_line;
  end

  assign busy_o = (state_q != IDLE) | reread_q;

endmodule : icache_refill

`default_nettype wire

/* icache_way_select.sv */
// ======================================
// merges the way lookups into one fetch response
// also holds the per-set PLRU bit used as refill victim
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_way_select
  import icache_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  way_rd_t [`ICACHE_WAY_NUM-1:0]       way_rd_i,
  input  logic [`ICACHE_ADDR_WIDTH-1:0]       s1_vaddr_i,
  input  logic                                s1_fetch_i,
  output fetch_rsp_t                          fetch_rsp_o,
  output logic                                miss_o,
  output logic [$clog2(`ICACHE_WAY_NUM)-1:0] victim_o
);

  logic [`ICACHE_WAY_NUM-1:0]          hit_vec;
  logic [$clog2(`ICACHE_WAY_NUM)-1:0] hit_way;
  logic                                any_hit;
  line_t                               hit_line;
  idx_t                                s1_idx;
  logic [`ICACHE_SET_NUM-1:0]          plru_q;

  // lowest hitting way wins
  always_comb begin
    hit_way = '0;
    for (int i = `ICACHE_WAY_NUM - 1; i >= 0; i--) begin
      hit_vec[i] = way_rd_i[i].hit;
      if (way_rd_i[i].hit) begin
        hit_way = i[$clog2(`ICACHE_WAY_NUM)-1:0];
      end
    end
  end

  assign any_hit  = |hit_vec;
  assign hit_line = way_rd_i[hit_way].line;
  assign s1_idx   = s1_vaddr_i[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH];

  // ======================================
  // response
  // ======================================
  assign fetch_rsp_o.valid = s1_fetch_i & any_hit;
  assign fetch_rsp_o.vaddr = s1_vaddr_i;
  assign fetch_rsp_o.instr = hit_line[s1_vaddr_i[`ICACHE_OFS_WIDTH-1:2]];

  assign miss_o = s1_fetch_i & ~any_hit;

  // PLRU, points away from the last hit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      plru_q <= '0;
    end else if (s1_fetch_i && any_hit) begin
      plru_q[s1_idx] <= ~hit_way;
    end
  end

  assign victim_o = plru_q[s1_idx];

endmodule : icache_way_select

`default_nettype wire

/* icache_lookup.sv */
// ======================================
// stage 0 acceptance and stage 1 holding registers
// invalidates win over fetches; picks the array read index
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_lookup
  import icache_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  fetch_req_t                    fetch_req_i,
  output logic                          fetch_ready_o,
  input  inval_req_t                    inval_req_i,
  output logic                          inval_ready_o,
  input  logic                          rsp_ready_i,
  input  logic                          miss_i,
  input  logic                          busy_i,
  output idx_t                          rd_idx_o,
  output tag_t                          s1_tag_o,
  output logic [`ICACHE_ADDR_WIDTH-1:0] s1_vaddr_o,
  output logic                          s1_fetch_o,
  output logic [`ICACHE_WAY_NUM-1:0]    clr_way_o,
  output idx_t                          clr_idx_o
);

  logic                                s1_fetch_q;
  logic                                s1_inval_q;
  logic [`ICACHE_ADDR_WIDTH-1:0]       s1_vaddr_q;
  logic [$clog2(`ICACHE_WAY_NUM)-1:0] s1_way_q;

  logic s1_empty;
  logic s1_hit_done;
  logic s1_advance;
  idx_t req_idx;
  idx_t s1_idx;

  // ======================================
  // stage 1 advance
  // ======================================
  assign s1_empty    = ~s1_fetch_q & ~s1_inval_q;
  assign s1_hit_done = s1_fetch_q & ~miss_i & rsp_ready_i;
  assign s1_advance  = ~busy_i & (s1_empty | s1_hit_done | s1_inval_q);

  assign inval_ready_o = s1_advance;
  assign fetch_ready_o = s1_advance & ~inval_req_i.valid;

  // read index follows the new request only when stage 1 moves
  assign req_idx  = inval_req_i.valid ? inval_req_i.idx
                                      : fetch_req_i.vaddr[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH];
  assign s1_idx   = s1_vaddr_q[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH];
  assign rd_idx_o = s1_advance ? req_idx : s1_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_fetch_q <= 1'b0;
      s1_inval_q <= 1'b0;
    end else if (s1_advance) begin
      s1_inval_q <= inval_req_i.valid;
      s1_fetch_q <= fetch_req_i.valid & ~inval_req_i.valid;
    end
  end

  // stage 1 address, an invalidate keeps only its index
  always_ff @(posedge clk) begin
    if (s1_advance) begin
      if (inval_req_i.valid) begin
        s1_vaddr_q <= {{`ICACHE_TAG_WIDTH{1'b0}}, inval_req_i.idx, {`ICACHE_OFS_WIDTH{1'b0}}};
      end else begin
        s1_vaddr_q <= fetch_req_i.vaddr;
      end
      s1_way_q <= inval_req_i.way;
    end
  end

  assign s1_tag_o   = s1_vaddr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
  assign s1_vaddr_o = s1_vaddr_q;
  assign s1_fetch_o = s1_fetch_q;

  // valid clear for the held invalidate
  always_comb begin
    clr_way_o = '0;
    if (s1_inval_q) begin
      clr_way_o[s1_way_q] = 1'b1;
    end
  end

  assign clr_idx_o = s1_idx;

endmodule : icache_lookup

`default_nettype wire

/* icache_way.sv */
// ======================================
// one cache way: tag, valid and data arrays
// one-cycle synchronous read, tag compare on the output
// ======================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_way
  import icache_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  idx_t    rd_idx_i,
  input  tag_t    s1_tag_i,
  input  way_wr_t fill_i,
  input  logic    fill_en_i,
  input  logic    clr_en_i,
  input  idx_t    clr_idx_i,
  output way_rd_t rd_o
);

  tag_t                       tag_mem  [`ICACHE_SET_NUM];
  line_t                      data_mem [`ICACHE_SET_NUM];
  logic [`ICACHE_SET_NUM-1:0] valid_q;

  tag_t  tag_rd_q;
  line_t line_rd_q;
  logic  valid_rd_q;

  // line fill
  always_ff @(posedge clk) begin
    if (fill_en_i) begin
      tag_mem[fill_i.idx]  <= fill_i.tag;
      data_mem[fill_i.idx] <= fill_i.line;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (clr_en_i) begin
        valid_q[clr_idx_i] <= 1'b0;
      end
      if (fill_en_i) begin
        valid_q[fill_i.idx] <= 1'b1;
      end
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    tag_rd_q  <= tag_mem[rd_idx_i];
    line_rd_q <= data_mem[rd_idx_i];
  end

  // a clear to the set being read wins over the old valid bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_rd_q <= 1'b0;
    end else begin
      valid_rd_q <= valid_q[rd_idx_i] & ~(clr_en_i & (clr_idx_i == rd_idx_i));
    end
  end

  assign rd_o.hit  = valid_rd_q & (tag_rd_q == s1_tag_i);
  assign rd_o.line = line_rd_q;

endmodule : icache_way

`default_nettype wire

/* icache_pkg.sv */
// ======================================
// shared types of the instruction cache
// request, response, bus and array structs
// ======================================

`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;
  typedef logic [`ICACHE_IDX_WIDTH-1:0] idx_t;
  typedef logic [`ICACHE_LINE_WORDS-1:0][31:0] line_t;

  // fetch side
  typedef struct packed {
    logic                          valid;
    logic [`ICACHE_ADDR_WIDTH-1:0] vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic                          valid;
    logic [`ICACHE_ADDR_WIDTH-1:0] vaddr;
    logic [31:0]                   instr;
  } fetch_rsp_t;

  // index invalidate, way given as a number
  typedef struct packed {
    logic                                valid;
    idx_t                                idx;
    logic [$clog2(`ICACHE_WAY_NUM)-1:0] way;
  } inval_req_t;

  // array side
  typedef struct packed {
    logic  hit;
    line_t line;
  } way_rd_t;

  typedef struct packed {
    logic [`ICACHE_WAY_NUM-1:0] way_en;
    idx_t                       idx;
    tag_t                       tag;
    line_t                      line;
  } way_wr_t;

  // ======================================
  // AXI read address and read data
  // ======================================
  typedef struct packed {
    logic                          valid;
    logic [`ICACHE_ADDR_WIDTH-1:0] addr;
    logic [7:0]                    len;
  } axi_ar_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
  } axi_r_t;

  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } refill_state_e;

endpackage : icache_pkg

`default_nettype wire

/* icache_consts.svh */
// ======================================
// instruction cache geometry and address split
// include in every cache source file that needs a size
// ======================================

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// associativity and set count
`define ICACHE_WAY_NUM 2
`define ICACHE_SET_NUM 16
`define ICACHE_IDX_WIDTH 4

// line layout, 4 words of 32 bits
`define ICACHE_LINE_WORDS 4
`define ICACHE_OFS_WIDTH 4

// fetch address split into tag, index and offset
`define ICACHE_ADDR_WIDTH 32
`define ICACHE_TAG_WIDTH (`ICACHE_ADDR_WIDTH - `ICACHE_IDX_WIDTH - `ICACHE_OFS_WIDTH)

`endif
